/* rtl/fetch_pkg.sv */
package fetch_pkg;

  // ==============================
  // address and line geometry
  // ==============================
  localparam int PC_W           = 32;
  localparam int INST_W         = 32;
  localparam int LINE_W         = 128;
  localparam int WORDS_PER_LINE = 4;
  localparam int OFFSET_W       = 4;
  localparam int LINE_ADDR_W    = PC_W - OFFSET_W;
  localparam logic [PC_W-1:0] RESET_PC = 32'h8000_0000;

  // line queue
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = 3;

  // line memory model
  localparam int MEM_LINES   = 32;
  localparam int MEM_IDX_W   = 5;
  localparam int MEM_LATENCY = 3;
  localparam int LAT_CNT_W   = 2;

  // read channel states
  localparam logic RD_IDLE = 1'b0;
  localparam logic RD_WAIT = 1'b1;

  // one cache line, raw or as instruction words
  typedef union packed {
    logic [LINE_W-1:0]                     raw;
    logic [WORDS_PER_LINE-1:0][INST_W-1:0] word;
  } fetch_line_u;

endpackage

/* rtl/line_queue.sv */
`timescale 1ns/100ps

module line_queue import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush_i,
  input  logic              wr_en_i,
  input  fetch_line_u       wr_line_i,
  input  logic              rd_en_i,
  output fetch_line_u       rd_line_o,
  output logic              full_o,
  output logic              empty_o,
  output logic [QPTR_W-2:0] count_o
);

  logic [QPTR_W-1:0] wr_ptr_q;
  logic [QPTR_W-1:0] rd_ptr_q;
  logic [QPTR_W-2:0] wr_idx;
  logic [QPTR_W-2:0] rd_idx;
  logic              wr_fire;
  logic              rd_fire;
  fetch_line_u       slots_q [QUEUE_DEPTH];

  assign wr_idx  = wr_ptr_q[QPTR_W-2:0];
  assign rd_idx  = rd_ptr_q[QPTR_W-2:0];
  assign wr_fire = wr_en_i & ~full_o;
  assign rd_fire = rd_en_i & ~empty_o;

  // ==============================
  // pointers
  // ==============================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr_q <= '0;
    end else if (wr_fire) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  // flush drops everything still queued
  always_ff @(posedge clk) begin
    if (rst_n) begin
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= wr_ptr_q;
    end else if (rd_fire) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // same index, wrap bit differs
  assign full_o  = (rd_ptr_q == {~wr_ptr_q[QPTR_W-1], wr_idx});
  assign empty_o = (rd_ptr_q == wr_ptr_q);
  assign count_o = wr_idx - rd_idx;

  // ==============================
  // storage
  // ==============================
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      slots_q[wr_idx] <= wr_line_i;
    end
  end

  // incoming line shows through when it lands on the head slot
  assign rd_line_o = (wr_fire && (wr_idx == rd_idx)) ? wr_line_i : slots_q[rd_idx];

endmodule

/* rtl/fetch_buffer.sv */
`timescale 1ns/100ps

module fetch_buffer import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // read address channel
  input  logic              ar_ready_i,
  output logic              ar_valid_o,
  output logic [PC_W-1:0]   ar_addr_o,
  // read data channel
  input  logic              r_valid_i,
  input  logic [LINE_W-1:0] r_data_i,
  output logic              r_ready_o,
  // fetch unit side
  input  logic              jmp_flush_i,
  input  logic [PC_W-1:0]   pc_i,
  output logic              inst_valid_o,
  output logic [INST_W-1:0] inst_o
);

  logic [LINE_ADDR_W-1:0] buf_line_q;
  logic [LINE_ADDR_W-1:0] pc_line;
  logic [LINE_ADDR_W-1:0] seq_line;
  logic                   pc_equal;
  logic                   pc_changed;

  logic                   state_q;
  logic                   ar_valid_q;
  logic                   stale_q;
  logic                   ar_xfer;
  logic                   r_xfer;

  logic                   q_wr_en;
  logic                   q_rd_en;
  logic                   q_full;
  logic                   q_empty;
  logic [QPTR_W-2:0]      q_count;
  fetch_line_u            in_line;
  fetch_line_u            head_line;

  // ==============================
  // pc line tracking
  // ==============================
  assign pc_line    = pc_i[PC_W-1:OFFSET_W];
  assign pc_equal   = (buf_line_q == pc_line);
  assign pc_changed = ~pc_equal;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      buf_line_q <= RESET_PC[PC_W-1:OFFSET_W];
    end else begin
      buf_line_q <= pc_line;
    end
  end

  // ==============================
  // read channel
  // ==============================
  assign ar_xfer = ar_valid_q & ar_ready_i;
  assign r_xfer  = r_valid_i & r_ready_o;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q    <= RD_IDLE;
      ar_valid_q <= 1'b0;
      stale_q    <= 1'b0;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (ar_xfer) begin
            state_q    <= RD_WAIT;
            ar_valid_q <= 1'b0;
          end else begin
            // no request while the queue has no room
            ar_valid_q <= ~q_full;
          end
        end
        RD_WAIT: begin
          if (r_xfer) begin
            state_q <= RD_IDLE;
            stale_q <= 1'b0;
          end else if (jmp_flush_i) begin
            // response in flight is for the old path
            stale_q <= 1'b1;
          end
        end
        default: begin
          state_q <= RD_IDLE;
        end
      endcase
    end
  end

  // next line to fetch sits just past what is queued
  assign seq_line   = buf_line_q + LINE_ADDR_W'(q_count);
  assign ar_valid_o = ar_valid_q;
  assign ar_addr_o  = jmp_flush_i ? {pc_line, {OFFSET_W{1'b0}}}
                                  : {seq_line, {OFFSET_W{1'b0}}};
  assign r_ready_o  = (state_q == RD_WAIT);

  // ==============================
  // line queue
  // ==============================
  assign in_line.raw = r_data_i;
  assign q_wr_en     = r_xfer & ~stale_q & ~jmp_flush_i;
  assign q_rd_en     = pc_changed & ~q_empty & ~jmp_flush_i;

  line_queue u_line_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush_i   (jmp_flush_i),
    .wr_en_i   (q_wr_en),
    .wr_line_i (in_line),
    .rd_en_i   (q_rd_en),
    .rd_line_o (head_line),
    .full_o    (q_full),
    .empty_o   (q_empty),
    .count_o   (q_count)
  );

  // head holds pc line, or the line lands in an empty queue this cycle
  assign inst_valid_o = pc_equal & (~q_empty | q_wr_en);

  // word select by pc bits 3 to 2
  assign inst_o = head_line.word[pc_i[OFFSET_W-1:2]];

endmodule

/* rtl/line_mem.sv */
`timescale 1ns/100ps

module line_mem import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ar_valid_i,
  input  logic [PC_W-1:0]   ar_addr_i,
  output logic              ar_ready_o,
  output logic              r_valid_o,
  output logic [LINE_W-1:0] r_data_o,
  input  logic              r_ready_i
);

  logic [LINE_W-1:0]    line_store [MEM_LINES];
  logic                 pending_q;
  logic                 r_valid_q;
  logic [LAT_CNT_W-1:0] lat_cnt_q;
  logic [MEM_IDX_W-1:0] idx_q;
  logic                 ar_xfer;
  logic                 rsp_load;
  fetch_line_u          rsp_line_q;

  initial begin
    $readmemh("test/inst.hex", line_store);
  end

  // one read at a time
  assign ar_ready_o = ~pending_q;
  assign ar_xfer    = ar_valid_i & ~pending_q;
  assign rsp_load   = pending_q & ~r_valid_q & (lat_cnt_q == LAT_CNT_W'(1));

  // ==============================
  // latency counter and response
  // ==============================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      pending_q <= 1'b0;
      r_valid_q <= 1'b0;
      lat_cnt_q <= '0;
    end else if (ar_xfer) begin
      pending_q <= 1'b1;
      lat_cnt_q <= LAT_CNT_W'(MEM_LATENCY);
    end else if (pending_q && !r_valid_q) begin
      lat_cnt_q <= lat_cnt_q - 1'b1;
      if (rsp_load) begin
        r_valid_q <= 1'b1;
      end
    end else if (r_valid_q && r_ready_i) begin
      r_valid_q <= 1'b0;
      pending_q <= 1'b0;
    end
  end

  // address bits 8 to 4, so the space wraps
  always_ff @(posedge clk) begin
    if (ar_xfer) begin
      idx_q <= ar_addr_i[OFFSET_W +: MEM_IDX_W];
    end
    if (rsp_load) begin
      rsp_line_q.raw <= line_store[idx_q];
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = rsp_line_q.raw;

endmodule

/* rtl/fetch_top.sv */
`timescale 1ns/100ps

module fetch_top import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [PC_W-1:0]   pc_i,
  input  logic              jmp_flush_i,
  output logic              inst_valid_o,
  output logic [INST_W-1:0] inst_o
);

  // read channel between buffer and memory
  logic              ar_valid;
  logic [PC_W-1:0]   ar_addr;
  logic              ar_ready;
  logic              r_valid;
  logic [LINE_W-1:0] r_data;
  logic              r_ready;

  fetch_buffer u_fetch_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar_ready_i   (ar_ready),
    .ar_valid_o   (ar_valid),
    .ar_addr_o    (ar_addr),
    .r_valid_i    (r_valid),
    .r_data_i     (r_data),
    .r_ready_o    (r_ready),
    .jmp_flush_i  (jmp_flush_i),
    .pc_i         (pc_i),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o)
  );

  line_mem u_line_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .r_ready_i  (r_ready)
  );

endmodule

/* test/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
  parameter int HALF_PERIOD_NS = 10
) (
  output logic clk_o
);

  // free running, starts low so the first rising edge is at 10 ns
  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end
  end

endmodule

/* test/fetch_assert.sv */
`timescale 1ns/100ps

module fetch_assert import fetch_pkg::*; (
  input logic              clk,
  input logic              rst_n,
  input logic [PC_W-1:0]   pc_i,
  input logic              jmp_flush_i,
  input logic              inst_valid_i,
  input logic [INST_W-1:0] inst_i
);

  logic [WORDS_PER_LINE-1:0][INST_W-1:0] ref_lines [MEM_LINES];
  logic [INST_W-1:0]                     exp_word;
  logic [7:0]                            since_reset_q;
  int unsigned                           fail_count = 0;

  initial begin
    $readmemh("test/inst.hex", ref_lines);
  end

  // line index from pc bits 8 to 4, word from pc bits 3 to 2
  assign exp_word = ref_lines[pc_i[OFFSET_W +: MEM_IDX_W]][pc_i[OFFSET_W-1:2]];

  // saturating count of cycles since reset release
  always_ff @(posedge clk) begin
    if (rst_n) begin
      since_reset_q <= '0;
    end else if (since_reset_q != 8'hff) begin
      since_reset_q <= since_reset_q + 8'd1;
    end
  end

  // ==============================
  // instruction data
  // ==============================
  a_inst_word: assert property (
    @(posedge clk) disable iff (rst_n)
    inst_valid_i |-> (inst_i == exp_word)
  ) else begin
    fail_count++;
    $error("error at %0t: inst_o %h at pc %h, expected %h", $time,
           $sampled(inst_i), $sampled(pc_i), $sampled(exp_word));
  end

  // once the line is present a held pc keeps the same word valid
  a_inst_stable: assert property (
    @(posedge clk) disable iff (rst_n)
    ($past(inst_valid_i) && $stable(pc_i)) |-> (inst_valid_i && $stable(inst_i))
  ) else begin
    fail_count++;
    $error("error at %0t: inst_o or inst_valid_o changed while pc_i was held", $time);
  end

  // ==============================
  // valid gaps
  // ==============================
  a_quiet_in_reset: assert property (
    @(posedge clk)
    (rst_n && $past(rst_n)) |-> !inst_valid_i
  ) else begin
    fail_count++;
    $error("error at %0t: inst_valid_o was high while reset was applied", $time);
  end

  // the first line needs the memory latency plus request and return
  a_first_fetch_gap: assert property (
    @(posedge clk) disable iff (rst_n)
    (since_reset_q < 8'(MEM_LATENCY + 2)) |-> !inst_valid_i
  ) else begin
    fail_count++;
    $error("error at %0t: inst_valid_o rose too soon after reset", $time);
  end

  a_flush_gap: assert property (
    @(posedge clk) disable iff (rst_n)
    (jmp_flush_i && (pc_i[PC_W-1:OFFSET_W] != $past(pc_i[PC_W-1:OFFSET_W])))
      |=> !inst_valid_i
  ) else begin
    fail_count++;
    $error("error at %0t: inst_valid_o was high in the cycle after a jump flush", $time);
  end

endmodule

bind fetch_top fetch_assert u_fetch_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .pc_i         (pc_i),
  .jmp_flush_i  (jmp_flush_i),
  .inst_valid_i (inst_valid_o),
  .inst_i       (inst_o)
);

/* test/fetch_tb.sv */
`timescale 1ns/100ps

module fetch_tb import fetch_pkg::*; ();

  localparam int RESET_CYCLES = 10;
  localparam int SEQ_COUNT    = 40;
  localparam int HOLD_COUNT   = 24;
  localparam int MAX_HOLD     = 4;
  localparam int JUMP_COUNT   = 6;
  localparam int MAX_RUN      = 8;
  localparam int WRAP_COUNT   = 16;
  localparam int TEST_COUNT   = 5;
  localparam int PLAN_INSTR   = 1 + SEQ_COUNT + HOLD_COUNT + 3 + (JUMP_COUNT - 1) * MAX_RUN
                                + WRAP_COUNT;
  localparam int LIMIT_CYCLES = RESET_CYCLES + PLAN_INSTR * (MEM_LATENCY + 4)
                                + HOLD_COUNT * MAX_HOLD + JUMP_COUNT * 4 + 100;

  logic              clk;
  logic              rst_n;
  logic [PC_W-1:0]   pc;
  logic              jmp_flush;
  logic              inst_valid;
  logic [INST_W-1:0] inst;

  logic [31:0]       lcg_state = 32'd65973;
  int unsigned       instr_count = 0;
  int unsigned       last_wait = 0;

  tb_clock u_clock (.clk_o(clk));

  fetch_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc),
    .jmp_flush_i  (jmp_flush),
    .inst_valid_o (inst_valid),
    .inst_o       (inst)
  );

  // ==============================
  // helpers
  // ==============================
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int unsigned pick_below(input int unsigned bound);
    logic [31:0] r;
    r = lcg_next();
    return {17'd0, r[30:16]} % bound;
  endfunction

  function automatic logic [PC_W-1:0] jump_target(input int unsigned line_idx,
                                                   input int unsigned word_idx);
    return RESET_PC + PC_W'(line_idx * 16 + word_idx * 4);
  endfunction

  function automatic int unsigned assertion_failures();
    return dut.u_fetch_assert.fail_count;
  endfunction

  // wait for a valid cycle, optionally hold pc, then step to the next word
  task automatic fetch_one(input int unsigned hold_cycles);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (!inst_valid) begin
      waited++;
      @(negedge clk);
    end
    last_wait = waited;
    repeat (hold_cycles) @(negedge clk);
    @(posedge clk);
    pc <= pc + 32'd4;
    instr_count++;
  endtask

  // one-cycle flush with the new pc, always to another line
  task automatic jump_to(input logic [PC_W-1:0] target);
    logic [PC_W-1:0] dest;
    @(posedge clk);
    dest = target;
    if (dest[PC_W-1:OFFSET_W] == pc[PC_W-1:OFFSET_W]) begin
      dest[OFFSET_W +: MEM_IDX_W] = dest[OFFSET_W +: MEM_IDX_W] + 5'd1;
    end
    pc        <= dest;
    jmp_flush <= 1'b1;
    @(posedge clk);
    jmp_flush <= 1'b0;
  endtask

  task automatic report_test(input string name, input int unsigned instr_mark,
                             input int unsigned fails_mark);
    $display("test %s: %0d instructions, %0d assertion failures", name,
             instr_count - instr_mark, assertion_failures() - fails_mark);
  endtask

  // ==============================
  // tests
  // ==============================
  initial begin : stimulus
    int unsigned     instr_mark;
    int unsigned     fails_mark;
    int unsigned     run_len;
    int unsigned     total_fails;
    logic [PC_W-1:0] target;
    rst_n     = 1'b1;
    pc        = RESET_PC;
    jmp_flush = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b0;

    fetch_one(0);
    $display("test reset: first instruction after %0d cycles, %0d assertion failures",
             last_wait, assertion_failures());

    instr_mark = instr_count;
    fails_mark = assertion_failures();
    repeat (SEQ_COUNT) fetch_one(0);
    report_test("sequential", instr_mark, fails_mark);

    instr_mark = instr_count;
    fails_mark = assertion_failures();
    repeat (HOLD_COUNT) fetch_one(pick_below(MAX_HOLD + 1));
    report_test("held pc", instr_mark, fails_mark);

    // first run stays in one line so the next flush meets a read in flight
    instr_mark = instr_count;
    fails_mark = assertion_failures();
    for (int j = 0; j < JUMP_COUNT; j++) begin
      if (j == 0) begin
        target  = jump_target(pick_below(MEM_LINES), 0);
        run_len = 3;
      end else begin
        target  = jump_target(pick_below(MEM_LINES), pick_below(WORDS_PER_LINE));
        run_len = 1 + pick_below(MAX_RUN);
      end
      jump_to(target);
      repeat (run_len) fetch_one(0);
    end
    report_test("jump flush", instr_mark, fails_mark);

    instr_mark = instr_count;
    fails_mark = assertion_failures();
    jump_to(jump_target(MEM_LINES - 2, 2));
    repeat (WRAP_COUNT) fetch_one(0);
    report_test("wrap", instr_mark, fails_mark);

    repeat (4) @(posedge clk);
    total_fails = assertion_failures();
    $display("summary: %0d tests, %0d instructions, %0d assertion failures",
             TEST_COUNT, instr_count, total_fails);
    if (total_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("timeout: no end of the tests after %0d cycles, fetch stopped delivering",
             LIMIT_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

/* test/inst.hex */
// one 128-bit line per row, word 3 on the left down to word 0 on the right
003a0493002a0493001a0493000a0493
013a0493012a0493011a0493010a0493
023a0493022a0493021a0493020a0493
033a0493032a0493031a0493030a0493
043a0493042a0493041a0493040a0493
053a0493052a0493051a0493050a0493
063a0493062a0493061a0493060a0493
073a0493072a0493071a0493070a0493
083a0493082a0493081a0493080a0493
093a0493092a0493091a0493090a0493
0a3a04930a2a04930a1a04930a0a0493
0b3a04930b2a04930b1a04930b0a0493
0c3a04930c2a04930c1a04930c0a0493
0d3a04930d2a04930d1a04930d0a0493
0e3a04930e2a04930e1a04930e0a0493
0f3a04930f2a04930f1a04930f0a0493
103a0493102a0493101a0493100a0493
113a0493112a0493111a0493110a0493
123a0493122a0493121a0493120a0493
133a0493132a0493131a0493130a0493
143a0493142a0493141a0493140a0493
153a0493152a0493151a0493150a0493
163a0493162a0493161a0493160a0493
173a0493172a0493171a0493170a0493
183a0493182a0493181a0493180a0493
193a0493192a0493191a0493190a0493
1a3a04931a2a04931a1a04931a0a0493
1b3a04931b2a04931b1a04931b0a0493
1c3a04931c2a04931c1a04931c0a0493
1d3a04931d2a04931d1a04931d0a0493
1e3a04931e2a04931e1a04931e0a0493
1f3a04931f2a04931f1a04931f0a0493

/* project.f */
rtl/fetch_pkg.sv
rtl/line_queue.sv
rtl/fetch_buffer.sv
rtl/line_mem.sv
rtl/fetch_top.sv
test/tb_clock.sv
test/fetch_assert.sv
test/fetch_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f project.f
./obj_dir/Vfetch_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
grep -q "sim passed" sim.log
